// File: Makefile
VERILATOR ?= verilator
TOP       ?= fp16SopTb
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log

SRCS := src.f $(shell grep -v '^+' src.f) $(wildcard src/*.svh) $(wildcard tb/*)
BIN  := obj_dir/V$(TOP)

.PHONY: all run check clean

all: check

obj_dir/V%: $(SRCS)
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f src.f --top-module $* -o V$*

run: $(BIN)
	./$(BIN) $(SEED_ARGS) 2>&1 | tee $(LOG)

check: run
	grep -q '^Test completed successfully$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: src.f
+incdir+src
src/fpFormatPkg.sv
src/sopPipePkg.sv
src/sopLink.sv
src/fp16ProductDecode.sv
src/fp32AlignAdd.sv
src/fp32RoundPack.sv
src/fp16SopTop.sv
tb/fp16SopTb.sv

// File: src/fp16ProductDecode.sv
`timescale 1ns/1ps
`include "sop_consts.svh"

module fp16ProductDecode (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fpFormatPkg::halfT topA,
	input fpFormatPkg::halfT topB,
	input fpFormatPkg::halfT botA,
	input fpFormatPkg::halfT botB,
	sopLink.src prods    // Product pair to execute
);
	import fpFormatPkg::*;
	import sopPipePkg::*;

	localparam int mulW = 2 * (`HALF_MAN_W + 1);             // Raw 11x11 product width
	localparam int padW = `SINGLE_MAN_W + 1 - mulW;           // Zero fill below product
	localparam logic [`SINGLE_EXP_W:0] rebias = `SINGLE_BIAS - 2 * `HALF_BIAS;

	prodPairT nextPair;

	// Exact product of two normal halves
	function automatic prodT mulHalf(input halfT a, input halfT b);
		logic [mulW-1:0] mp;
		prodT p;
		mp = {1'b1, a.fraction} * {1'b1, b.fraction};   // In [2^20, 2^22)
		p.sign = a.sign ^ b.sign;
		if (mp[mulW-1]) begin
			p.mantissa = {mp, {padW{1'b0}}};            // Already at the top
		end else begin
			p.mantissa = {mp[mulW-2:0], {(padW + 1){1'b0}}};    // One place up
		end
		// Ea + Eb - 2*15 + 127, plus one when the product carried
		p.exponent = 9'(a.exponent) + 9'(b.exponent) + 9'(mp[mulW-1]) + rebias;
		return p;
	endfunction

	// Neither zero/subnormal nor inf/NaN
	function automatic logic isNormal(input halfT h);
		return (h.exponent != '0) && (h.exponent != '1);
	endfunction

	always_comb begin
		nextPair.top = mulHalf(topA, topB);
		nextPair.bot = mulHalf(botA, botB);
	end

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			prods.valid <= 1'b0;
		end else begin
			prods.valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		prods.payload <= nextPair;    // Qualified by valid downstream
	end

	// Special operands are outside the datapath's range
	operandsNormal: assert property (@(posedge clk) disable iff (rst)
		inValid |-> isNormal(topA) && isNormal(topB) && isNormal(botA) && isNormal(botB))
		else $error("non-normal operand sampled");

endmodule

// File: src/fp16SopTop.sv
`timescale 1ns/1ps

// topA*topB + botA*botB, one rounding to single precision
module fp16SopTop (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fpFormatPkg::halfT topA,
	input fpFormatPkg::halfT topB,
	input fpFormatPkg::halfT botA,
	input fpFormatPkg::halfT botB,
	output logic outValid,               // Four cycles after inValid
	output fpFormatPkg::singleT result,
	output logic inexact
);
	import sopPipePkg::*;

	sopLink #(.payloadT(prodPairT)) prodLink ();    // Decode to execute
	sopLink #(.payloadT(normT)) normLink ();        // Execute to result

	fp16ProductDecode decode (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.topA(topA),
		.topB(topB),
		.botA(botA),
		.botB(botB),
		.prods(prodLink.src)
	);

	fp32AlignAdd execute (
		.clk(clk),
		.rst(rst),
		.prods(prodLink.dst),
		.norm(normLink.src)
	);

	fp32RoundPack resultStage (
		.clk(clk),
		.rst(rst),
		.norm(normLink.dst),
		.outValid(outValid),
		.result(result),
		.inexact(inexact)
	);

endmodule

// File: src/fp32AlignAdd.sv
`timescale 1ns/1ps
`include "sop_consts.svh"

module fp32AlignAdd (
	input logic clk,
	input logic rst,
	sopLink.dst prods,    // From decode
	sopLink.src norm      // To result stage
);
	import fpFormatPkg::*;
	import sopPipePkg::*;

	localparam int alignW = `SINGLE_MAN_W + 1 + `GRS_W;   // Mantissa plus GRS, 27
	localparam int shW = $clog2(alignW + 1);             // Holds 0..alignW

	////////////////////////////////////////////////////////////
	// Step one, order and align
	////////////////////////////////////////////////////////////

	prodPairT inPair;
	prodT bigP;
	prodT smallP;
	logic swap;
	logic [`SINGLE_EXP_W:0] expDiff;
	logic [shW-1:0] shAmt;
	logic [2*alignW-1:0] wideSmall;     // Upper half kept, lower half shifted out
	alignedT nextAligned;
	alignedT alignReg;
	logic alignValid;

	assign inPair = prods.payload;
	assign swap = {inPair.bot.exponent, inPair.bot.mantissa} >
		{inPair.top.exponent, inPair.top.mantissa};    // Magnitude compare
	assign bigP = swap ? inPair.bot : inPair.top;
	assign smallP = swap ? inPair.top : inPair.bot;
	assign expDiff = bigP.exponent - smallP.exponent;
	// Past alignW everything lands in sticky anyway
	assign shAmt = (expDiff > 9'(alignW)) ? shW'(alignW) : expDiff[shW-1:0];
	assign wideSmall = {smallP.mantissa, {(`GRS_W + alignW){1'b0}}} >> shAmt;

	always_comb begin
		nextAligned.sign = bigP.sign;
		nextAligned.exponent = bigP.exponent;
		nextAligned.bigMant = bigP.mantissa;
		// Lowest kept bit absorbs everything shifted out
		nextAligned.smallMant = {wideSmall[2*alignW-1:alignW+1],
			wideSmall[alignW] | (|wideSmall[alignW-1:0])};
		nextAligned.effSub = bigP.sign ^ smallP.sign;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= prods.valid;
		end
	end

	always_ff @(posedge clk) begin
		alignReg <= nextAligned;
	end

	////////////////////////////////////////////////////////////
	// Step two, add and normalize
	////////////////////////////////////////////////////////////

	logic [alignW-1:0] bigExt;
	logic [alignW:0] sum;              // One carry bit on top
	logic [shW-1:0] lz;
	logic [alignW-1:0] shifted;
	normT nextNorm;

	// Leading zeros of a non-carry sum, alignW when all zero
	function automatic logic [shW-1:0] leadZeros(input logic [alignW-1:0] v);
		logic [shW-1:0] n;
		n = shW'(alignW);
		for (int i = 0; i < alignW; i++) begin
			if (v[i]) n = shW'(alignW - 1 - i);    // Highest set bit wins
		end
		return n;
	endfunction

	assign bigExt = {alignReg.bigMant, {`GRS_W{1'b0}}};
	// Big is never below small, so the difference stays positive
	assign sum = alignReg.effSub ? {1'b0, bigExt} - {1'b0, alignReg.smallMant}
		: {1'b0, bigExt} + {1'b0, alignReg.smallMant};
	assign lz = leadZeros(sum[alignW-1:0]);
	assign shifted = sum[alignW-1:0] << lz;

	always_comb begin
		nextNorm.sign = alignReg.sign;
		nextNorm.zero = (sum == '0);   // Only on exact cancellation
		if (sum[alignW]) begin
			// Carry out, one place right
			nextNorm.exponent = alignReg.exponent + 9'd1;
			nextNorm.mantissa = sum[alignW:`GRS_W+1];
			nextNorm.guard = sum[`GRS_W];
			nextNorm.round = sum[`GRS_W-1];
			nextNorm.sticky = |sum[`GRS_W-2:0];
		end else begin
			// Left by leading zeros, large only after cancellation
			nextNorm.exponent = alignReg.exponent - 9'(lz);
			nextNorm.mantissa = shifted[alignW-1:`GRS_W];
			nextNorm.guard = shifted[`GRS_W-1];
			nextNorm.round = shifted[`GRS_W-2];
			nextNorm.sticky = shifted[0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			norm.valid <= 1'b0;
		end else begin
			norm.valid <= alignValid;
		end
	end

	always_ff @(posedge clk) begin
		norm.payload <= nextNorm;
	end

endmodule

// File: src/fp32RoundPack.sv
`timescale 1ns/1ps
`include "sop_consts.svh"

module fp32RoundPack (
	input logic clk,
	input logic rst,
	sopLink.dst norm,                    // Normalized sum from execute
	output logic outValid,
	output fpFormatPkg::singleT result,
	output logic inexact
);
	import fpFormatPkg::*;
	import sopPipePkg::*;

	normT n;
	logic roundUp;
	logic [`SINGLE_MAN_W+1:0] mantUp;    // Room for the rounding carry
	logic [`SINGLE_EXP_W:0] finalExp;
	singleT packed32;

	assign n = norm.payload;

	// Round to nearest, ties to even
	assign roundUp = n.guard & (n.round | n.sticky | n.mantissa[0]);
	assign mantUp = {1'b0, n.mantissa} + 25'(roundUp);
	assign finalExp = n.exponent + 9'(mantUp[`SINGLE_MAN_W+1]);    // 1.11..1 rolled over

	always_comb begin
		packed32.sign = n.sign;
		packed32.exponent = finalExp[`SINGLE_EXP_W-1:0];
		if (mantUp[`SINGLE_MAN_W+1]) begin
			packed32.fraction = mantUp[`SINGLE_MAN_W:1];    // Renormalize
		end else begin
			packed32.fraction = mantUp[`SINGLE_MAN_W-1:0];
		end
		if (n.zero) begin
			packed32 = '0;    // Plus zero
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= norm.valid;
		end
	end

	always_ff @(posedge clk) begin
		result <= packed32;
		inexact <= n.guard | n.round | n.sticky;
	end

	// Normal operands keep the sum far from the top of the range
	noExpOverflow: assert property (@(posedge clk) disable iff (rst)
		norm.valid && !n.zero |-> finalExp < 9'((1 << `SINGLE_EXP_W) - 1))
		else $error("result exponent overflow");

endmodule

// File: src/fpFormatPkg.sv
`include "sop_consts.svh"

package fpFormatPkg;

	////////////////////////////////////////////////////////////
	// IEEE 754 storage formats
	////////////////////////////////////////////////////////////

	// Binary16 operand word
	typedef struct packed {
		logic sign;
		logic [`HALF_EXP_W-1:0] exponent;    // Biased by 15
		logic [`HALF_MAN_W-1:0] fraction;
	} halfT;

	// Binary32 result word
	typedef struct packed {
		logic sign;
		logic [`SINGLE_EXP_W-1:0] exponent;  // Biased by 127
		logic [`SINGLE_MAN_W-1:0] fraction;
	} singleT;

	////////////////////////////////////////////////////////////
	// Unpacked operand
	////////////////////////////////////////////////////////////

	// One exact half x half product in single precision range
	// Extra exponent bit keeps headroom for the adder stages
	typedef struct packed {
		logic sign;
		logic [`SINGLE_EXP_W:0] exponent;    // Single bias, 9 bits
		logic [`SINGLE_MAN_W:0] mantissa;    // Hidden one at the top
	} prodT;

endpackage

// File: src/sopLink.sv
`timescale 1ns/1ps

// Stage to stage link of the pipeline
// No ready signal, every stage advances each cycle
interface sopLink #(
	parameter type payloadT = logic
);
	logic valid;         // Item present this cycle
	payloadT payload;    // Don't care while valid is low

	// Producing stage
	modport src (
		output valid,
		output payload
	);

	// Consuming stage
	modport dst (
		input valid,
		input payload
	);
endinterface

// File: src/sopPipePkg.sv
`include "sop_consts.svh"

package sopPipePkg;

	////////////////////////////////////////////////////////////
	// Decode to execute
	////////////////////////////////////////////////////////////

	// Both products of one operand set
	typedef struct packed {
		fpFormatPkg::prodT top;    // topA x topB
		fpFormatPkg::prodT bot;    // botA x botB
	} prodPairT;

	////////////////////////////////////////////////////////////
	// Inside execute, align step to add step
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sign;                                 // Sign of larger product
		logic [`SINGLE_EXP_W:0] exponent;           // Common exponent
		logic [`SINGLE_MAN_W:0] bigMant;            // Larger mantissa
		logic [`SINGLE_MAN_W+`GRS_W:0] smallMant;   // Shifted smaller one plus GRS
		logic effSub;                               // Signs differ
	} alignedT;

	////////////////////////////////////////////////////////////
	// Execute to result
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sign;
		logic [`SINGLE_EXP_W:0] exponent;
		logic [`SINGLE_MAN_W:0] mantissa;   // Normalized, hidden one at top
		logic guard;
		logic round;
		logic sticky;
		logic zero;                         // Exact cancellation
	} normT;

endpackage

// File: src/sop_consts.svh
`ifndef SOP_CONSTS_SVH
`define SOP_CONSTS_SVH

////////////////////////////////////////////////////////////
// Number format fields
////////////////////////////////////////////////////////////

// Half precision operands
`define HALF_EXP_W 5
`define HALF_MAN_W 10      // Stored fraction, hidden one not counted

// Single precision products and result
`define SINGLE_EXP_W 8
`define SINGLE_MAN_W 23    // Stored fraction, hidden one not counted

// Exponent biases
`define HALF_BIAS 15
`define SINGLE_BIAS 127

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

// Guard, round and sticky below the aligned mantissa
`define GRS_W 3

// Input sample to registered result
`define SOP_LATENCY 4      // Decode 1, execute 2, result 1

`endif

// File: tb/fp16SopTb.sv
`timescale 1ns/1ps
`include "sop_consts.svh"

module fp16SopTb;
	import fpFormatPkg::*;

	logic clk;
	logic rst;
	logic inValid;
	halfT topA;
	halfT topB;
	halfT botA;
	halfT botB;
	logic outValid;
	singleT result;
	logic inexact;

	integer seed;
	singleT expResult[$];    // Scoreboard, oldest first
	logic expInexact[$];
	logic [`SOP_LATENCY-1:0] validHist;    // inValid seen at past negedges
	int timingErrors;
	int valueErrors;
	int otherErrors;
	int checked;
	int waited;

	fp16SopTop DUT (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.topA(topA),
		.topB(topB),
		.botA(botA),
		.botB(botB),
		.outValid(outValid),
		.result(result),
		.inexact(inexact)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;    // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Exact sum as a scaled integer, then one RNE rounding to 24 bits
	function automatic void expectSop(input halfT a, input halfT b, input halfT c,
		input halfT d, output singleT res, output logic inex);
		longint pTop;
		longint pBot;
		longint sum;
		longint mag;
		longint kept;
		longint rem;
		longint halfUlp;
		int eTop;
		int eBot;
		int eMin;
		int msb;
		int sh;
		int expUnb;
		// Half value is m * 2^(e-25), so a product is pm * 2^(ea+eb-50)
		pTop = longint'({1'b1, a.fraction}) * longint'({1'b1, b.fraction});
		pBot = longint'({1'b1, c.fraction}) * longint'({1'b1, d.fraction});
		if (a.sign ^ b.sign) pTop = -pTop;
		if (c.sign ^ d.sign) pBot = -pBot;
		eTop = a.exponent + b.exponent;
		eBot = c.exponent + d.exponent;
		eMin = (eTop < eBot) ? eTop : eBot;
		sum = (pTop <<< (eTop - eMin)) + (pBot <<< (eBot - eMin));    // Exact
		res = '0;
		inex = 1'b0;
		if (sum != 0) begin
			res.sign = (sum < 0);
			mag = (sum < 0) ? -sum : sum;
			msb = 0;
			for (int i = 0; i < 63; i++) begin
				if (mag[i]) msb = i;
			end
			sh = msb - 23;    // Places to drop for a 24-bit mantissa
			if (sh > 0) begin
				kept = mag >> sh;
				rem = mag - (kept << sh);
				halfUlp = longint'(1) << (sh - 1);
				inex = (rem != 0);
				if (rem > halfUlp || (rem == halfUlp && kept[0])) kept++;    // Ties to even
				if (kept == (longint'(1) << 24)) begin
					kept = kept >> 1;    // Carry past the top
					sh++;
				end
			end else begin
				kept = mag << (-sh);    // Fits, no rounding
			end
			expUnb = 23 + sh + eMin - 50;
			res.exponent = 8'(expUnb + 127);
			res.fraction = kept[22:0];
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Normal half, exponent field 10..20
	function automatic halfT randHalf();
		halfT h;
		h.sign = 1'($random(seed));
		h.exponent = 5'(10 + $unsigned($random(seed)) % 11);
		h.fraction = 10'($random(seed));
		return h;
	endfunction

	function automatic halfT negate(input halfT h);
		halfT n;
		n = h;
		n.sign = ~h.sign;
		return n;
	endfunction

	// One operand set on the next cycle, expected values queued
	task automatic sendSet(input halfT a, input halfT b, input halfT c, input halfT d);
		singleT r;
		logic x;
		@(posedge clk);
		#1;
		topA = a;
		topB = b;
		botA = c;
		botB = d;
		inValid = 1'b1;
		expectSop(a, b, c, d, r, x);
		expResult.push_back(r);
		expInexact.push_back(x);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			inValid = 1'b0;    // Operands left as they were
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor and scoreboard
	////////////////////////////////////////////////////////////

	task automatic checkResult();
		singleT er;
		logic ei;
		assert (expResult.size() > 0) else begin
			otherErrors++;
			$display("Result appeared at %0t with no item in flight", $time);
		end
		if (expResult.size() > 0) begin
			er = expResult.pop_front();
			ei = expInexact.pop_front();
			checked++;
			assert (result === er) else begin
				valueErrors++;
				$display("[ERROR] %0t result: got %h expected %h", $time, result, er);
			end
			assert (inexact === ei) else begin
				valueErrors++;
				$display("[ERROR] %0t inexact: got %b expected %b", $time, inexact, ei);
			end
		end
	endtask

	// Negedge sampling, outputs and inputs both settled
	always @(negedge clk) begin
		if (rst) begin
			validHist = '0;
		end else begin
			assert (outValid === validHist[`SOP_LATENCY-1]) else begin
				timingErrors++;
				$display("[ERROR] %0t outValid: got %b expected %b", $time, outValid,
					validHist[`SOP_LATENCY-1]);
			end
			if (outValid === 1'b1) checkResult();
			validHist = {validHist[`SOP_LATENCY-2:0], inValid};
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		halfT cancelA;
		halfT cancelB;
		seed = 32'h29d2b227;
		timingErrors = 0;
		valueErrors = 0;
		otherErrors = 0;
		checked = 0;
		rst = 1'b1;
		inValid = 1'b0;
		topA = 16'h3C00;    // 1.0, a harmless normal value
		topB = 16'h3C00;
		botA = 16'h3C00;
		botB = 16'h3C00;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		idleCycles(2 * `SOP_LATENCY);    // Quiet pipe after reset

		// Exact cancellation gives plus zero
		sendSet(16'h4A3F, 16'h3C55, negate(16'h4A3F), 16'h3C55);
		for (int i = 0; i < 8; i++) begin
			cancelA = randHalf();
			cancelB = randHalf();
			sendSet(cancelA, cancelB, negate(cancelA), cancelB);
		end

		// Halfway cases, 1.0 plus a tiny product
		sendSet(16'h3C00, 16'h3C00, 16'h0C00, 16'h0C00);    // 1 + 2^-24, stays at 1.0
		sendSet(16'h3C00, 16'h3C00, 16'h0E00, 16'h1000);    // 1 + 3*2^-24, goes up
		sendSet(negate(16'h3C00), 16'h3C00, negate(16'h0E00), 16'h1000);
		sendSet(16'h3C01, 16'h3C00, 16'h0C00, 16'h0C00);    // Even low bit, down
		idleCycles(3);

		// Random sets, back to back with random gaps
		for (int i = 0; i < 2000; i++) begin
			sendSet(randHalf(), randHalf(), randHalf(), randHalf());
			if ($unsigned($random(seed)) % 4 == 0) begin
				idleCycles(1 + $unsigned($random(seed)) % 3);
			end
		end
		idleCycles(1);

		waited = 0;
		while (expResult.size() > 0 && waited < 20 * `SOP_LATENCY) begin
			@(posedge clk);
			waited++;
		end
		if (expResult.size() > 0) begin
			otherErrors++;
			$display("Timed out with %0d results still outstanding", expResult.size());
		end
		idleCycles(2 * `SOP_LATENCY);    // Catch stray outputs

		$display("Checked %0d results: %0d timing errors, %0d value errors, %0d other errors",
			checked, timingErrors, valueErrors, otherErrors);
		if (timingErrors + valueErrors + otherErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
